// File: flist.f
logic/csr_pkg.sv
logic/csr_decode.sv
logic/csr_regfile.sv
logic/cycle_counter.sv
logic/trap_ctrl.sv
logic/csr_unit_top.sv
bench/tb_clk_gen.sv
bench/tb_checker.sv
bench/tb_csr_unit.sv

// File: bench/tb_csr_unit.sv
`timescale 1ns/100ps

module tb_csr_unit import csr_pkg::*; ();

    localparam int          CLK_PERIOD  = 20;
    localparam int          DRIVE_DELAY = 2;
    localparam logic [31:0] PC_BASE     = 32'h0000_4002;

    // kind selects how the checker forms the expected csr_rdata
    typedef struct packed {
        logic        valid;
        logic [31:0] instr;
        logic [31:0] pc;
        logic [31:0] rs1;
        logic        exc;
        logic [31:0] cause;
        logic [1:0]  kind;
        logic [31:0] rdata;
        logic        redirect;
        logic [31:0] redirect_pc;
    } row_t;

    logic        clk;
    logic        rst_n;
    logic [31:0] csr_rdata;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic        flush;
    logic        check_en;
    int          err_count;
    bit          table_built;
    row_t        cur;
    row_t        rows[$];

    // expected CSR contents while the table is built
    logic [31:0] seed;
    logic [31:0] mtvec_m;
    logic [31:0] mepc_m;
    logic [31:0] mstatus_m;
    logic [31:0] mcause_m;
    logic [31:0] cyc_off;

    tb_clk_gen clk_gen_i (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    csr_unit_top csr_unit_top_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid_i (cur.valid),
        .pc_i          (cur.pc),
        .instr_i       (cur.instr),
        .rs1_data_i    (cur.rs1),
        .exc_i         (cur.exc),
        .exc_cause_i   (cur.cause),
        .csr_rdata_o   (csr_rdata),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .flush_o       (flush)
    );

    tb_checker check_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .check_en_i        (check_en),
        .exp_kind_i        (cur.kind),
        .exp_rdata_i       (cur.rdata),
        .exp_redirect_i    (cur.redirect),
        .exp_redirect_pc_i (cur.redirect_pc),
        .csr_rdata_i       (csr_rdata),
        .redirect_i        (redirect),
        .redirect_pc_i     (redirect_pc),
        .flush_i           (flush),
        .err_count_o       (err_count)
    );

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [31:0] encode_csr(input logic [2:0] f3, input logic [4:0] ri,
                                               input logic [11:0] addr);
        return {addr, ri, f3, 5'd1, OPCODE_SYSTEM};
    endfunction

    function automatic logic [31:0] row_pc();
        return PC_BASE + 32'(rows.size()) * 32'd4;
    endfunction

    task automatic push_row(input logic v, input logic [31:0] ins, input logic [31:0] d,
                            input logic ex, input logic [31:0] cause, input logic [1:0] kind,
                            input logic [31:0] rd, input logic redir, input logic [31:0] rpc);
        row_t r;
        r = {v, ins, row_pc(), d, ex, cause, kind, rd, redir, rpc};
        rows.push_back(r);
    endtask

    // trapping row followed by a flushed row that tries a write and an exception
    task automatic raise_trap(input logic [31:0] ins, input logic ex, input logic [31:0] cause,
                              input logic [31:0] rd);
        mepc_m = row_pc() & ~32'd3;
        push_row(1'b1, ins, next_rand(), ex, cause, 2'd0, rd, 1'b0, 32'd0);
        mcause_m = ex ? cause : 32'd2;
        mstatus_m[MSTATUS_MPIE_BIT] = mstatus_m[MSTATUS_MIE_BIT];
        mstatus_m[MSTATUS_MIE_BIT]  = 1'b0;
        push_row(1'b1, encode_csr(FUNCT3_CSRRW, 5'd7, ADDR_MTVEC), next_rand(), 1'b1, 32'd7,
                 2'd0, mtvec_m, 1'b1, mtvec_m);
    endtask

    task automatic return_from_trap();
        push_row(1'b1, INSTR_MRET, next_rand(), 1'b0, 32'd0, 2'd0, 32'd0, 1'b0, 32'd0);
        push_row(1'b1, encode_csr(FUNCT3_CSRRW, 5'd7, ADDR_MTVEC), next_rand(), 1'b1, 32'd7,
                 2'd0, mtvec_m, 1'b1, mepc_m);
        // restore lands at the end of the flushed row
        mstatus_m[MSTATUS_MIE_BIT]  = mstatus_m[MSTATUS_MPIE_BIT];
        mstatus_m[MSTATUS_MPIE_BIT] = 1'b1;
    endtask

    task automatic csr_access(input logic [2:0] f3, input logic [11:0] addr,
                              input logic [4:0] ri, input logic [31:0] d);
        logic [31:0] old;
        logic [31:0] nv;
        logic [1:0]  kind;
        kind = 2'd0;
        old  = 32'd0;
        case (addr)
            ADDR_MTVEC:   old = mtvec_m;
            ADDR_MEPC:    old = mepc_m;
            ADDR_MSTATUS: old = mstatus_m;
            ADDR_MCAUSE:  old = mcause_m;
            ADDR_MCYCLE: begin
                old  = cyc_off;
                kind = 2'd1;
            end
            ADDR_MCYCLEH: kind = 2'd2;
            default:      kind = 2'd3;
        endcase
        if (kind == 2'd3) begin
            // unknown address reads zero and traps with cause 2
            raise_trap(encode_csr(f3, ri, addr), 1'b0, 32'd0, 32'd0);
        end else begin
            case (f3)
                FUNCT3_CSRRW: nv = d;
                FUNCT3_CSRRS: nv = old | d;
                default:      nv = old & ~d;
            endcase
            push_row(1'b1, encode_csr(f3, ri, addr), d, 1'b0, 32'd0, kind, old, 1'b0, 32'd0);
            if (f3 == FUNCT3_CSRRW || ri != 5'd0) begin
                case (addr)
                    ADDR_MTVEC:   mtvec_m   = nv & ~32'd3;
                    ADDR_MEPC:    mepc_m    = nv & ~32'd3;
                    ADDR_MSTATUS: mstatus_m = nv;
                    ADDR_MCAUSE:  mcause_m  = nv;
                    // loaded at the next edge and counting goes on from there
                    ADDR_MCYCLE:  cyc_off   = d - 32'(rows.size()) - 32'd1;
                    default: ;
                endcase
            end
        end
    endtask

    task automatic build_table();
        csr_access(FUNCT3_CSRRW, ADDR_MTVEC, 5'd1, next_rand());
        csr_access(FUNCT3_CSRRS, ADDR_MTVEC, 5'd0, next_rand());
        csr_access(FUNCT3_CSRRW, ADDR_MEPC, 5'd1, next_rand());
        csr_access(FUNCT3_CSRRS, ADDR_MEPC, 5'd0, next_rand());
        csr_access(FUNCT3_CSRRW, ADDR_MSTATUS, 5'd1, next_rand());
        csr_access(FUNCT3_CSRRS, ADDR_MSTATUS, 5'd0, next_rand());
        csr_access(FUNCT3_CSRRW, ADDR_MCAUSE, 5'd1, next_rand());
        csr_access(FUNCT3_CSRRS, ADDR_MCAUSE, 5'd0, next_rand());
        // random set and clear masks and x0 forms that must not write
        csr_access(FUNCT3_CSRRS, ADDR_MEPC, 5'd5, next_rand());
        csr_access(FUNCT3_CSRRC, ADDR_MCAUSE, 5'd6, next_rand());
        csr_access(FUNCT3_CSRRC, ADDR_MTVEC, 5'd0, next_rand());
        csr_access(FUNCT3_CSRRS, ADDR_MEPC, 5'd0, next_rand());
        csr_access(FUNCT3_CSRRS, ADDR_MCAUSE, 5'd0, next_rand());
        csr_access(FUNCT3_CSRRS, ADDR_MTVEC, 5'd0, next_rand());
        // MIE set and MPIE clear ahead of the exception
        csr_access(FUNCT3_CSRRS, ADDR_MSTATUS, 5'd2, 32'h0000_0008);
        csr_access(FUNCT3_CSRRC, ADDR_MSTATUS, 5'd2, 32'h0000_0080);
        raise_trap(encode_csr(FUNCT3_CSRRW, 5'd3, ADDR_MCAUSE), 1'b1, 32'h0000_000b, mcause_m);
        csr_access(FUNCT3_CSRRS, ADDR_MEPC, 5'd0, next_rand());
        csr_access(FUNCT3_CSRRS, ADDR_MCAUSE, 5'd0, next_rand());
        csr_access(FUNCT3_CSRRS, ADDR_MSTATUS, 5'd0, next_rand());
        csr_access(FUNCT3_CSRRS, ADDR_MTVEC, 5'd0, next_rand());
        return_from_trap();
        csr_access(FUNCT3_CSRRS, ADDR_MSTATUS, 5'd0, next_rand());
        csr_access(FUNCT3_CSRRW, 12'h344, 5'd3, next_rand());
        csr_access(FUNCT3_CSRRS, ADDR_MCAUSE, 5'd0, next_rand());
        csr_access(FUNCT3_CSRRS, ADDR_MEPC, 5'd0, next_rand());
        // MPIE clear before a second mret so that setting MPIE shows
        csr_access(FUNCT3_CSRRC, ADDR_MSTATUS, 5'd2, 32'h0000_0080);
        return_from_trap();
        csr_access(FUNCT3_CSRRS, ADDR_MSTATUS, 5'd0, next_rand());
        csr_access(FUNCT3_CSRRS, ADDR_MCYCLE, 5'd0, next_rand());
        csr_access(FUNCT3_CSRRS, ADDR_MCYCLEH, 5'd0, next_rand());
        csr_access(FUNCT3_CSRRW, ADDR_MCYCLE, 5'd4, 32'h0010_0000);
        csr_access(FUNCT3_CSRRS, ADDR_MCYCLE, 5'd0, next_rand());
        csr_access(FUNCT3_CSRRS, ADDR_MCYCLE, 5'd0, next_rand());
        csr_access(FUNCT3_CSRRS, ADDR_MCYCLEH, 5'd0, next_rand());
    endtask

    initial begin
        cur       = '0;
        check_en  = 1'b0;
        seed      = 32'hd268_6dbc;
        mtvec_m   = 32'd0;
        mepc_m    = 32'd0;
        mstatus_m = MSTATUS_RESET;
        mcause_m  = 32'd0;
        cyc_off   = 32'd0;
        build_table();
        table_built = 1'b1;
        wait (rst_n === 1'b1);
        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            cur      = rows[i];
            check_en = 1'b1;
        end
        @(posedge clk);
        #DRIVE_DELAY;
        cur      = '0;
        check_en = 1'b0;
        $display("%0d rows checked, %0d errors", rows.size(), err_count);
        if (err_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // watchdog allows ten spare cycles beyond the table
    initial begin
        wait (table_built);
        #((rows.size() + 10) * CLK_PERIOD);
        $display("run timed out after %0d cycles", rows.size() + 10);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// File: bench/tb_checker.sv
`timescale 1ns/100ps

module tb_checker (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        check_en_i,
    input  logic [1:0]  exp_kind_i,
    input  logic [31:0] exp_rdata_i,
    input  logic        exp_redirect_i,
    input  logic [31:0] exp_redirect_pc_i,
    input  logic [31:0] csr_rdata_i,
    input  logic        redirect_i,
    input  logic [31:0] redirect_pc_i,
    input  logic        flush_i,
    output int          err_count_o
);

    localparam int SAMPLE_DELAY = 18;

    logic [63:0] edges;
    logic [31:0] exp_rdata;

    initial begin
        edges       = 64'd0;
        err_count_o = 0;
    end

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("ERR %s expected %h got %h at %0t", name, exp, act, $time);
            err_count_o = err_count_o + 1;
        end
    endtask

    // edges since reset release, the same edges mcycle counts
    always @(posedge clk) begin
        if (rst_n) begin
            edges = edges + 64'd1;
        end
        #SAMPLE_DELAY;
        if (check_en_i) begin
            // kind 1 is the low count plus an offset, kind 2 the high count
            case (exp_kind_i)
                2'd1:    exp_rdata = edges[31:0] + exp_rdata_i;
                2'd2:    exp_rdata = edges[63:32];
                default: exp_rdata = exp_rdata_i;
            endcase
            compare("csr_rdata_o", exp_rdata, csr_rdata_i);
            compare("redirect_o", {31'd0, exp_redirect_i}, {31'd0, redirect_i});
            compare("flush_o", {31'd0, exp_redirect_i}, {31'd0, flush_i});
            if (exp_redirect_i) begin
                compare("redirect_pc_o", exp_redirect_pc_i, redirect_pc_i);
            end
        end
    end

endmodule

// File: bench/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    localparam int HALF_PERIOD = 10;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // release on a falling edge, clear of the rising edges
    initial begin
        rst_n_o = 1'b0;
        repeat (2) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

// File: logic/csr_unit_top.sv
`timescale 1ns/100ps

module csr_unit_top import csr_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            instr_valid_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] instr_i,
    input  logic [XLEN-1:0] rs1_data_i,
    input  logic            exc_i,
    input  logic [XLEN-1:0] exc_cause_i,
    output logic [XLEN-1:0] csr_rdata_o,
    output logic            redirect_o,
    output logic [XLEN-1:0] redirect_pc_o,
    output logic            flush_o
);

    csr_op_e         csr_op;
    logic [11:0]     csr_addr;
    logic            csr_we;
    logic            illegal;
    logic            accept;
    logic            we_gated;
    logic            trap_enter;
    logic            trap_return;
    logic [XLEN-1:0] trap_cause;
    logic [XLEN-1:0] wdata;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mepc;
    logic [63:0]     cycle;

    // no write from a trapping or flushed slot
    assign we_gated = csr_we & accept;

    csr_decode csr_decode_i (
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .csr_op_o      (csr_op),
        .csr_addr_o    (csr_addr),
        .csr_we_o      (csr_we),
        .illegal_o     (illegal)
    );

    csr_regfile csr_regfile_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .csr_op_i      (csr_op),
        .csr_addr_i    (csr_addr),
        .csr_we_i      (we_gated),
        .rs1_data_i    (rs1_data_i),
        .pc_i          (pc_i),
        .trap_enter_i  (trap_enter),
        .trap_return_i (trap_return),
        .trap_cause_i  (trap_cause),
        .cycle_i       (cycle),
        .csr_rdata_o   (csr_rdata_o),
        .wdata_o       (wdata),
        .mtvec_o       (mtvec),
        .mepc_o        (mepc)
    );

    cycle_counter cycle_counter_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .csr_addr_i (csr_addr),
        .csr_we_i   (we_gated),
        .wdata_i    (wdata),
        .cycle_o    (cycle)
    );

    trap_ctrl trap_ctrl_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid_i (instr_valid_i),
        .csr_op_i      (csr_op),
        .illegal_i     (illegal),
        .exc_i         (exc_i),
        .exc_cause_i   (exc_cause_i),
        .mtvec_i       (mtvec),
        .mepc_i        (mepc),
        .trap_enter_o  (trap_enter),
        .trap_return_o (trap_return),
        .trap_cause_o  (trap_cause),
        .accept_o      (accept),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o),
        .flush_o       (flush_o)
    );

endmodule

// File: logic/trap_ctrl.sv
`timescale 1ns/100ps

module trap_ctrl import csr_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            instr_valid_i,
    input  csr_op_e         csr_op_i,
    input  logic            illegal_i,
    input  logic            exc_i,
    input  logic [XLEN-1:0] exc_cause_i,
    input  logic [XLEN-1:0] mtvec_i,
    input  logic [XLEN-1:0] mepc_i,
    output logic            trap_enter_o,
    output logic            trap_return_o,
    output logic [XLEN-1:0] trap_cause_o,
    output logic            accept_o,
    output logic            redirect_o,
    output logic [XLEN-1:0] redirect_pc_o,
    output logic            flush_o
);

    trap_state_e state_q;
    trap_state_e state_d;
    logic        idle;
    logic        trap;
    logic        mret;

    assign idle = (state_q == ST_IDLE);

    // events count only in idle, other slots are flushed
    assign trap = idle && (exc_i || (instr_valid_i && illegal_i));
    assign mret = idle && instr_valid_i && (csr_op_i == OP_MRET);

    // external exception takes precedence
    assign trap_cause_o = exc_i ? exc_cause_i : CAUSE_ILLEGAL_INSTR;

    always_comb begin
        state_d = ST_IDLE;
        if (trap) begin
            state_d = ST_ENTER;
        end else if (mret) begin
            state_d = ST_RETURN;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign trap_enter_o  = trap;
    assign trap_return_o = (state_q == ST_RETURN);
    assign accept_o      = idle && !trap;

    // one cycle after the event
    assign redirect_o    = !idle;
    assign flush_o       = !idle;
    assign redirect_pc_o = (state_q == ST_RETURN) ? mepc_i : {mtvec_i[XLEN-1:2], 2'b00};

endmodule

// File: logic/cycle_counter.sv
`timescale 1ns/100ps

module cycle_counter import csr_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [11:0]     csr_addr_i,
    input  logic            csr_we_i,
    input  logic [XLEN-1:0] wdata_i,
    output logic [63:0]     cycle_o
);

    logic [63:0] cycle_q;
    logic [63:0] cycle_inc;

    assign cycle_inc = cycle_q + 64'd1;

    // a written half is loaded, the other half keeps counting
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle_q <= '0;
        end else if (csr_we_i && csr_addr_i == ADDR_MCYCLE) begin
            cycle_q <= {cycle_inc[63:32], wdata_i};
        end else if (csr_we_i && csr_addr_i == ADDR_MCYCLEH) begin
            cycle_q <= {wdata_i, cycle_inc[31:0]};
        end else begin
            cycle_q <= cycle_inc;
        end
    end

    assign cycle_o = cycle_q;

endmodule

// File: logic/csr_regfile.sv
`timescale 1ns/100ps

module csr_regfile import csr_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  csr_op_e         csr_op_i,
    input  logic [11:0]     csr_addr_i,
    input  logic            csr_we_i,
    input  logic [XLEN-1:0] rs1_data_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic            trap_enter_i,
    input  logic            trap_return_i,
    input  logic [XLEN-1:0] trap_cause_i,
    input  logic [63:0]     cycle_i,
    output logic [XLEN-1:0] csr_rdata_o,
    output logic [XLEN-1:0] wdata_o,
    output logic [XLEN-1:0] mtvec_o,
    output logic [XLEN-1:0] mepc_o
);

    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mstatus;
    logic [XLEN-1:0] mcause;
    logic [XLEN-1:0] rdata;
    logic [XLEN-1:0] wdata;
    logic            is_csr;
    logic            sel_mepc;
    logic            sel_mtvec;
    logic            sel_mstatus;
    logic            sel_mcause;
    logic            sel_mcycle;
    logic            sel_mcycleh;

    assign is_csr = (csr_op_i == OP_RW) || (csr_op_i == OP_RS) || (csr_op_i == OP_RC);

    assign sel_mepc    = is_csr && (csr_addr_i == ADDR_MEPC);
    assign sel_mtvec   = is_csr && (csr_addr_i == ADDR_MTVEC);
    assign sel_mstatus = is_csr && (csr_addr_i == ADDR_MSTATUS);
    assign sel_mcause  = is_csr && (csr_addr_i == ADDR_MCAUSE);
    assign sel_mcycle  = is_csr && (csr_addr_i == ADDR_MCYCLE);
    assign sel_mcycleh = is_csr && (csr_addr_i == ADDR_MCYCLEH);

    // one-hot and-or mux, zero when nothing selected
    assign rdata = ({XLEN{sel_mepc}}    & mepc)
                 | ({XLEN{sel_mtvec}}   & mtvec)
                 | ({XLEN{sel_mstatus}} & mstatus)
                 | ({XLEN{sel_mcause}}  & mcause)
                 | ({XLEN{sel_mcycle}}  & cycle_i[31:0])
                 | ({XLEN{sel_mcycleh}} & cycle_i[63:32]);

    always_comb begin
        case (csr_op_i)
            OP_RW:   wdata = rs1_data_i;
            OP_RS:   wdata = rdata | rs1_data_i;
            OP_RC:   wdata = rdata & ~rs1_data_i;
            default: wdata = '0;
        endcase
    end

    assign csr_rdata_o = rdata;
    assign wdata_o     = wdata;
    assign mtvec_o     = mtvec;
    assign mepc_o      = mepc;

    // trap updates win over csr writes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mepc    <= '0;
            mtvec   <= '0;
            mstatus <= MSTATUS_RESET;
            mcause  <= '0;
        end else if (trap_enter_i) begin
            mepc    <= {pc_i[XLEN-1:2], 2'b00};
            mcause  <= trap_cause_i;
            mstatus[MSTATUS_MPIE_BIT] <= mstatus[MSTATUS_MIE_BIT];
            mstatus[MSTATUS_MIE_BIT]  <= 1'b0;
        end else if (trap_return_i) begin
            mstatus[MSTATUS_MIE_BIT]  <= mstatus[MSTATUS_MPIE_BIT];
            mstatus[MSTATUS_MPIE_BIT] <= 1'b1;
        end else if (csr_we_i) begin
            if (sel_mepc) begin
                mepc <= {wdata[XLEN-1:2], 2'b00};
            end
            if (sel_mtvec) begin
                // direct mode only, low bits stay zero
                mtvec <= {wdata[XLEN-1:2], 2'b00};
            end
            if (sel_mstatus) begin
                mstatus <= wdata;
            end
            if (sel_mcause) begin
                mcause <= wdata;
            end
        end
    end

endmodule

// File: logic/csr_decode.sv
`timescale 1ns/100ps

module csr_decode import csr_pkg::*; (
    input  logic            instr_valid_i,
    input  logic [XLEN-1:0] instr_i,
    output csr_op_e         csr_op_o,
    output logic [11:0]     csr_addr_o,
    output logic            csr_we_o,
    output logic            illegal_o
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [4:0]  rs1_idx;
    logic [11:0] addr;
    logic        is_csr;
    logic        addr_known;
    csr_op_e     op;

    assign opcode  = instr_i[6:0];
    assign funct3  = instr_i[14:12];
    assign rs1_idx = instr_i[19:15];
    assign addr    = instr_i[31:20];

    // only register-form CSR ops and mret are recognised
    always_comb begin
        op = OP_NONE;
        if (instr_valid_i && opcode == OPCODE_SYSTEM) begin
            if (instr_i == INSTR_MRET) begin
                op = OP_MRET;
            end else begin
                case (funct3)
                    FUNCT3_CSRRW: op = OP_RW;
                    FUNCT3_CSRRS: op = OP_RS;
                    FUNCT3_CSRRC: op = OP_RC;
                    default:      op = OP_NONE;
                endcase
            end
        end
    end

    assign is_csr = (op == OP_RW) || (op == OP_RS) || (op == OP_RC);

    assign addr_known = (addr == ADDR_MSTATUS) || (addr == ADDR_MTVEC) ||
                        (addr == ADDR_MEPC)    || (addr == ADDR_MCAUSE) ||
                        (addr == ADDR_MCYCLE)  || (addr == ADDR_MCYCLEH);

    assign csr_op_o   = op;
    assign csr_addr_o = is_csr ? addr : 12'h000;

    // set/clear with rs1 = x0 is a pure read
    assign csr_we_o = (op == OP_RW) ||
                      (((op == OP_RS) || (op == OP_RC)) && (rs1_idx != 5'd0));

    assign illegal_o = is_csr && !addr_known;

endmodule

// File: logic/csr_pkg.sv
package csr_pkg;

    // data path width, fixed for RV32
    localparam int XLEN = 32;

    // implemented machine-mode CSR addresses
    localparam logic [11:0] ADDR_MSTATUS = 12'h300;
    localparam logic [11:0] ADDR_MTVEC   = 12'h305;
    localparam logic [11:0] ADDR_MEPC    = 12'h341;
    localparam logic [11:0] ADDR_MCAUSE  = 12'h342;
    localparam logic [11:0] ADDR_MCYCLE  = 12'hB00;
    localparam logic [11:0] ADDR_MCYCLEH = 12'hB80;

    // instruction fields
    localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;
    localparam logic [2:0] FUNCT3_CSRRW  = 3'b001;
    localparam logic [2:0] FUNCT3_CSRRS  = 3'b010;
    localparam logic [2:0] FUNCT3_CSRRC  = 3'b011;
    localparam logic [XLEN-1:0] INSTR_MRET = 32'h3020_0073;

    // trap cause for an unknown CSR address
    localparam logic [XLEN-1:0] CAUSE_ILLEGAL_INSTR = 32'd2;

    // MPP = 2'b11, machine mode only
    localparam logic [XLEN-1:0] MSTATUS_RESET = 32'h0000_1800;
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;

    typedef enum logic [2:0] {
        OP_NONE = 3'd0,
        OP_RW   = 3'd1,
        OP_RS   = 3'd2,
        OP_RC   = 3'd3,
        OP_MRET = 3'd4
    } csr_op_e;

    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_ENTER  = 2'd1,
        ST_RETURN = 2'd2
    } trap_state_e;

endpackage
